// File: ringPkg.sv
package ringPkg;

    //====================
    // ring slot fields
    //====================

    localparam int tagW  = 4;   // requestor tag, wraps at 16
    localparam int dataW = 32;  // one data word per slot
    localparam int addrW = 32;  // full byte-style address, see tileMapPkg for fields

    //====================
    // message kinds
    //====================

    // requests sit in the low half, responses in the high half
    typedef enum logic [2:0] {
        OP_RD       = 3'd0,  // read one word
        OP_WR       = 3'd1,  // write one word
        OP_BCAST_WR = 3'd2,  // write same word index in every tile
        OP_RD_RSP   = 3'd4,  // read data back
        OP_WR_RSP   = 3'd5,  // write done
        OP_ERR_RSP  = 3'd6   // nobody claimed the request
    } opcodeT;

    // true for the three request kinds
    function automatic logic isRequest(opcodeT op);
        return op inside {OP_RD, OP_WR, OP_BCAST_WR};
    endfunction

    // a slot is (valid, tag, opcode, address, data), carried as loose signals
    // the same slot is reused for the response, so the ring never needs a
    // second channel or any buffering

endpackage

// File: tileMapPkg.sv
package tileMapPkg;

    //====================
    // address map
    //====================

    // address layout, low bits only
    //   [coreIdLsb +: coreIdW]  target tile
    //   [wordIdxW-1:0]          word inside the tile store
    // all other bits are ignored by the tiles

    localparam int coreIdW   = 4;   // core ids 1..14 used, 0 and 15 unclaimed
    localparam int coreIdLsb = 8;   // core id field starts at bit 8

    //====================
    // local store
    //====================

    localparam int wordIdxW = 4;               // word index from addr[3:0]
    localparam int memDepth = 2 ** wordIdxW;   // 16 words per tile

    // broadcast writes use only the word index, the core id field
    // of a broadcast is don't care

endpackage

// File: ringInjector.sv
module ringInjector
import ringPkg::*;
(
    input  logic              QClk,
    input  logic              arstN,
    // host request strobe
    input  logic              hostReqValid,
    input  opcodeT            hostReqOpcode,
    input  logic [addrW-1:0]  hostReqAddress,
    input  logic [dataW-1:0]  hostReqData,
    // from collector
    input  logic              drained,
    // ring origin slot
    output logic              slotValid,
    output logic [tagW-1:0]   slotTag,
    output opcodeT            slotOpcode,
    output logic [addrW-1:0]  slotAddress,
    output logic [dataW-1:0]  slotData,
    // in-flight count
    output logic [4:0]        hostOutstanding
);

logic [tagW-1:0] tagCnt;   // next tag to hand out

//====================
// control
//====================
always_ff @(posedge QClk or negedge arstN) begin
    if (!arstN) begin
        slotValid       <= 1'b0;
        tagCnt          <= '0;
        hostOutstanding <= '0;
    end else begin
        slotValid <= hostReqValid;  // origin slot always free, take every strobe
        if (hostReqValid) begin
            tagCnt <= tagCnt + 1'b1;  // wraps at 16
        end
        // up on accept, down on drain, both may hit in one cycle
        hostOutstanding <= hostOutstanding + 5'(hostReqValid) - 5'(drained);
    end
end

//====================
// payload
//====================
always_ff @(posedge QClk) begin
    if (hostReqValid) begin
        slotTag     <= tagCnt;
        slotOpcode  <= hostReqOpcode;
        slotAddress <= hostReqAddress;
        slotData    <= hostReqData;
    end
end

// no stall path, the returning slot is drained at the origin
// so slot 0 is never occupied when the host strobes

endmodule

// File: ringTile.sv
module ringTile
import ringPkg::*;
import tileMapPkg::*;
#(
    parameter int coreId = 1   // set by the generate loop in lotrRing
)
(
    input  logic              QClk,
    input  logic              arstN,
    // slot from previous ring stop
    input  logic              inValid,
    input  logic [tagW-1:0]   inTag,
    input  opcodeT            inOpcode,
    input  logic [addrW-1:0]  inAddress,
    input  logic [dataW-1:0]  inData,
    // slot to next ring stop
    output logic              outValid,
    output logic [tagW-1:0]   outTag,
    output opcodeT            outOpcode,
    output logic [addrW-1:0]  outAddress,
    output logic [dataW-1:0]  outData
);

localparam logic [coreIdW-1:0] myId = coreIdW'(coreId);

logic [dataW-1:0]    store [memDepth];  // local store
logic [memDepth-1:0] wordValid;         // word written since reset

logic [coreIdW-1:0]  slotCoreId;
logic [wordIdxW-1:0] wordIdx;
logic                hit;
logic                claimRd;
logic                claimWr;
logic                bcastWr;
logic                doWrite;
logic [dataW-1:0]    readWord;
opcodeT              nextOpcode;
logic [dataW-1:0]    nextData;

//====================
// decode
//====================
assign slotCoreId = inAddress[coreIdLsb +: coreIdW];
assign wordIdx    = inAddress[wordIdxW-1:0];
assign hit        = inValid && (slotCoreId == myId);

assign claimRd = hit && (inOpcode == OP_RD);
assign claimWr = hit && (inOpcode == OP_WR);
assign bcastWr = inValid && (inOpcode == OP_BCAST_WR);  // every tile, any core id
assign doWrite = claimWr || bcastWr;

// unwritten words read as zero
assign readWord = wordValid[wordIdx] ? store[wordIdx] : '0;

// turn the slot into its response in place
always_comb begin
    nextOpcode = inOpcode;  // forward by default
    nextData   = inData;
    if (claimRd) begin
        nextOpcode = OP_RD_RSP;
        nextData   = readWord;  // old content, no write in a read slot
    end else if (claimWr) begin
        nextOpcode = OP_WR_RSP;
    end
    // broadcast passes on unchanged, collector answers it
end

//====================
// store
//====================
always_ff @(posedge QClk) begin
    if (doWrite) begin
        store[wordIdx] <= inData;
    end
end

always_ff @(posedge QClk or negedge arstN) begin
    if (!arstN) begin
        wordValid <= '0;  // whole store reads 0 after reset
    end else if (doWrite) begin
        wordValid[wordIdx] <= 1'b1;
    end
end

//====================
// output slot
//====================
always_ff @(posedge QClk or negedge arstN) begin
    if (!arstN) begin
        outValid <= 1'b0;
    end else begin
        outValid <= inValid;  // one cycle per stop, served or not
    end
end

always_ff @(posedge QClk) begin
    if (inValid) begin
        outTag     <= inTag;
        outOpcode  <= nextOpcode;
        outAddress <= inAddress;
        outData    <= nextData;
    end
end

// a request is only served once, a response slot has a response
// opcode and is never claimed again further down the ring
// (isRequest is checked at the collector)

endmodule

// File: ringCollector.sv
module ringCollector
import ringPkg::*;
(
    input  logic              QClk,
    input  logic              arstN,
    // slot coming back to the ring origin
    input  logic              inValid,
    input  logic [tagW-1:0]   inTag,
    input  opcodeT            inOpcode,
    input  logic [addrW-1:0]  inAddress,
    input  logic [dataW-1:0]  inData,
    // host response strobe
    output logic              hostRspValid,
    output logic [tagW-1:0]   hostRspTag,
    output opcodeT            hostRspOpcode,
    output logic [dataW-1:0]  hostRspData,
    // to injector
    output logic              drained
);

opcodeT rspOpcode;

// a request that made it all the way round was not served
always_comb begin
    rspOpcode = inOpcode;
    if (isRequest(inOpcode)) begin
        if (inOpcode == OP_BCAST_WR) begin
            rspOpcode = OP_WR_RSP;  // every tile wrote it
        end else begin
            rspOpcode = OP_ERR_RSP;  // core id nobody owns
        end
    end
end

// slot leaves the ring at this edge
assign drained = inValid;

//====================
// host response
//====================
always_ff @(posedge QClk or negedge arstN) begin
    if (!arstN) begin
        hostRspValid  <= 1'b0;
        hostRspTag    <= '0;
        hostRspOpcode <= OP_ERR_RSP;  // idle value, still a response kind
        hostRspData   <= '0;
    end else begin
        hostRspValid <= inValid;
        if (inValid) begin
            hostRspTag    <= inTag;
            hostRspOpcode <= rspOpcode;
            hostRspData   <= inData;  // error keeps request data
        end
    end
end

// address only matters on the way round, the host matches by tag

endmodule

// File: lotrRing.sv
module lotrRing
import ringPkg::*;
#(
    parameter int numTiles = 3   // 1..14, core ids 1..numTiles
)
(
    input  logic              QClk,
    input  logic              arstN,
    // host request
    input  logic              hostReqValid,
    input  opcodeT            hostReqOpcode,
    input  logic [addrW-1:0]  hostReqAddress,
    input  logic [dataW-1:0]  hostReqData,
    // host response
    output logic              hostRspValid,
    output logic [tagW-1:0]   hostRspTag,
    output opcodeT            hostRspOpcode,
    output logic [dataW-1:0]  hostRspData,
    output logic [4:0]        hostOutstanding
);

//====================
// ring slots
//====================
// index = ring position, 0 is the origin, numTiles returns to the origin
logic              slotValid   [0:numTiles];
logic [tagW-1:0]   slotTag     [0:numTiles];
opcodeT            slotOpcode  [0:numTiles];
logic [addrW-1:0]  slotAddress [0:numTiles];
logic [dataW-1:0]  slotData    [0:numTiles];

logic drained;  // collector -> injector

//====================
// origin
//====================
ringInjector ringInjector0 (
    .QClk            (QClk),
    .arstN           (arstN),
    .hostReqValid    (hostReqValid),
    .hostReqOpcode   (hostReqOpcode),
    .hostReqAddress  (hostReqAddress),
    .hostReqData     (hostReqData),
    .drained         (drained),
    .slotValid       (slotValid[0]),
    .slotTag         (slotTag[0]),
    .slotOpcode      (slotOpcode[0]),
    .slotAddress     (slotAddress[0]),
    .slotData        (slotData[0]),
    .hostOutstanding (hostOutstanding)
);

//====================
// tiles
//====================
for (genvar k = 1; k <= numTiles; k++) begin : genTile
    ringTile #(
        .coreId (k)
    ) ringTile0 (
        .QClk       (QClk),
        .arstN      (arstN),
        .inValid    (slotValid[k-1]),    // from previous stop
        .inTag      (slotTag[k-1]),
        .inOpcode   (slotOpcode[k-1]),
        .inAddress  (slotAddress[k-1]),
        .inData     (slotData[k-1]),
        .outValid   (slotValid[k]),      // to next stop
        .outTag     (slotTag[k]),
        .outOpcode  (slotOpcode[k]),
        .outAddress (slotAddress[k]),
        .outData    (slotData[k])
    );
end

// ring closure, last slot drains back at the origin
ringCollector ringCollector0 (
    .QClk          (QClk),
    .arstN         (arstN),
    .inValid       (slotValid[numTiles]),
    .inTag         (slotTag[numTiles]),
    .inOpcode      (slotOpcode[numTiles]),
    .inAddress     (slotAddress[numTiles]),
    .inData        (slotData[numTiles]),
    .hostRspValid  (hostRspValid),
    .hostRspTag    (hostRspTag),
    .hostRspOpcode (hostRspOpcode),
    .hostRspData   (hostRspData),
    .drained       (drained)
);

endmodule

// File: lotrRing_assertions.sv
module lotrRing_assertions
import ringPkg::*;
#(
    parameter int numTiles = 3   // taken from the bound lotrRing
)
(
    input  logic   QClk,
    input  logic   arstN,
    input  logic   hostReqValid,
    input  logic   hostRspValid,
    input  opcodeT hostRspOpcode
);
timeunit 1ns;
timeprecision 100ps;

int failCount = 0;  // read by the testbench at the end

//====================
// port properties
//====================
rspQuietInReset: assert property (@(posedge QClk) !arstN |-> !hostRspValid)
    else begin
        $error("response strobe seen while reset is asserted");
        failCount++;
    end

// every slot travels the whole ring, fixed latency
rspAfterReq: assert property (@(posedge QClk) disable iff (!arstN)
    hostReqValid |-> ##(numTiles + 2) hostRspValid)
    else begin
        $error("request strobe without response %0d cycles later", numTiles + 2);
        failCount++;
    end

rspKind: assert property (@(posedge QClk) disable iff (!arstN)
    hostRspOpcode inside {OP_RD_RSP, OP_WR_RSP, OP_ERR_RSP})
    else begin
        $error("response opcode is not a response kind");
        failCount++;
    end

endmodule

bind lotrRing lotrRing_assertions #(.numTiles(numTiles)) asrt0 (
    .QClk          (QClk),
    .arstN         (arstN),
    .hostReqValid  (hostReqValid),
    .hostRspValid  (hostRspValid),
    .hostRspOpcode (hostRspOpcode)
);

// File: lotrRing_tb.sv
module lotrRing_tb
import ringPkg::*;
import tileMapPkg::*;
();
timeunit 1ns;
timeprecision 100ps;

localparam int numTiles    = 3;
localparam int clkPeriod   = 100;
localparam int resetCycles = 5;
localparam int totalReqs   = 48 + 60 + 52 + 4 + 40;  // sum over the five tests

logic             QClk;
logic             arstN;
logic             hostReqValid;
opcodeT           hostReqOpcode;
logic [addrW-1:0] hostReqAddress;
logic [dataW-1:0] hostReqData;
logic             hostRspValid;
logic [tagW-1:0]  hostRspTag;
opcodeT           hostRspOpcode;
logic [dataW-1:0] hostRspData;
logic [4:0]       hostOutstanding;

logic [dataW-1:0] model [16][memDepth];  // reference stores, by core id
logic [tagW-1:0]  nextTag = '0;           // mirrors the injector counter
opcodeT           expOp [$];
logic [dataW-1:0] expData [$];
logic [tagW-1:0]  expTag [$];
int               expCycle [$];
int cycleCnt = 0;
int reqSeen = 0;
int rspSeen = 0;
int valueErrs = 0;
int latencyErrs = 0;
int missingErrs = 0;
int assertErrs = 0;

lotrRing #(.numTiles(numTiles)) dut0 (.*);

initial begin
    QClk = 1'b0;
    forever #(clkPeriod / 2) QClk = ~QClk;
end

// cycle count and strobe count, both taken at the rising edge
always @(posedge QClk) begin
    cycleCnt <= cycleCnt + 1;
    if (arstN && hostReqValid) reqSeen <= reqSeen + 1;
end

//====================
// compare tasks
//====================
task automatic compareOpcode(input opcodeT got, input opcodeT exp);
    if (got !== exp) begin
        $display("error at %0t: opcode %s, expected %s", $time, got.name(), exp.name());
        valueErrs++;
    end
endtask

task automatic compareData(input logic [dataW-1:0] got, input logic [dataW-1:0] exp);
    if (got !== exp) begin
        $display("error at %0t: data %h, expected %h", $time, got, exp);
        valueErrs++;
    end
endtask

task automatic compareTag(input logic [tagW-1:0] got, input logic [tagW-1:0] exp);
    if (got !== exp) begin
        $display("error at %0t: tag %0d, expected %0d", $time, got, exp);
        valueErrs++;
    end
endtask

task automatic compareCount(input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
        $display("error at %0t: outstanding %0d, expected %0d", $time, got, exp);
        valueErrs++;
    end
endtask

//====================
// response monitor
//====================
always @(negedge QClk) begin
    if (arstN) begin
        if (hostRspValid) begin
            rspSeen = rspSeen + 1;
            if (expTag.size() == 0) begin
                $display("a response with tag %0d came with none expected", hostRspTag);
                missingErrs++;
            end else begin
                if (cycleCnt != expCycle[0]) begin
                    $display("error at %0t: response in cycle %0d, expected %0d",
                             $time, cycleCnt, expCycle[0]);
                    latencyErrs++;
                end
                compareTag(hostRspTag, expTag.pop_front());
                compareOpcode(hostRspOpcode, expOp.pop_front());
                compareData(hostRspData, expData.pop_front());
                void'(expCycle.pop_front());
            end
        end
        // oldest request overdue
        if (expCycle.size() != 0 && cycleCnt > expCycle[0]) begin
            $display("the response for tag %0d never arrived", expTag[0]);
            missingErrs++;
            void'(expCycle.pop_front());
            void'(expTag.pop_front());
            void'(expOp.pop_front());
            void'(expData.pop_front());
        end
        compareCount(hostOutstanding, 5'(reqSeen - rspSeen));
    end
end

//====================
// stimulus
//====================
// called on a falling edge, leaves the strobe low one cycle later
task automatic sendReq(input opcodeT op, input logic [coreIdW-1:0] core,
                       input logic [wordIdxW-1:0] word, input logic [dataW-1:0] data);
    logic             claimed;
    opcodeT           rspOp;
    logic [dataW-1:0] rspData;
    logic [addrW-1:0] addr;
    claimed = (core >= 1) && (core <= numTiles);
    rspOp   = OP_ERR_RSP;  // unclaimed keeps request data
    rspData = data;
    if (op == OP_BCAST_WR) begin
        rspOp = OP_WR_RSP;
        for (int k = 1; k <= numTiles; k++) model[k][word] = data;
    end else if (claimed && op == OP_RD) begin
        rspOp   = OP_RD_RSP;
        rspData = model[core][word];
    end else if (claimed) begin
        rspOp = OP_WR_RSP;
        model[core][word] = data;
    end
    addr = $urandom;  // bits outside the fields are noise
    addr[coreIdLsb +: coreIdW] = core;
    addr[wordIdxW-1:0]         = word;
    hostReqValid   = 1'b1;
    hostReqOpcode  = op;
    hostReqAddress = addr;
    hostReqData    = data;
    expOp.push_back(rspOp);
    expData.push_back(rspData);
    expTag.push_back(nextTag);
    expCycle.push_back(cycleCnt + numTiles + 2);
    nextTag = nextTag + 1'b1;
    @(negedge QClk);
    hostReqValid = 1'b0;
endtask

task automatic drain();
    while (expTag.size() != 0) @(negedge QClk);
    repeat (2) @(negedge QClk);
endtask

task automatic readAll();
    for (int c = 1; c <= numTiles; c++)
        for (int w = 0; w < memDepth; w++)
            sendReq(OP_RD, coreIdW'(c), wordIdxW'(w), $urandom);
endtask

//====================
// directed tests
//====================
task automatic resetStateTest();
    repeat (3) @(negedge QClk);  // idle, monitor flags any stray response
    readAll();
    drain();
endtask

task automatic targetedWriteTest();
    for (int c = 1; c <= numTiles; c++)
        repeat (4) sendReq(OP_WR, coreIdW'(c), wordIdxW'($urandom_range(0, 15)), $urandom);
    readAll();  // untouched words still 0
    drain();
endtask

task automatic unclaimedTest();
    sendReq(OP_RD, 4'd0, wordIdxW'($urandom_range(0, 15)), $urandom);
    sendReq(OP_WR, 4'd0, wordIdxW'($urandom_range(0, 15)), $urandom);
    sendReq(OP_RD, 4'd15, wordIdxW'($urandom_range(0, 15)), $urandom);
    sendReq(OP_WR, 4'd15, wordIdxW'($urandom_range(0, 15)), $urandom);
    readAll();  // stores untouched by the unclaimed writes
    drain();
endtask

task automatic broadcastTest();
    logic [wordIdxW-1:0] word;
    word = wordIdxW'($urandom_range(0, 15));
    sendReq(OP_BCAST_WR, coreIdW'($urandom_range(0, 15)), word, $urandom);
    for (int c = 1; c <= numTiles; c++) sendReq(OP_RD, coreIdW'(c), word, $urandom);
    drain();
endtask

task automatic burstTest();
    opcodeT op;
    for (int i = 0; i < 40; i++) begin
        op = ($urandom_range(0, 1) != 0) ? OP_WR : OP_RD;
        sendReq(op, coreIdW'($urandom_range(1, numTiles)),
                wordIdxW'($urandom_range(0, 15)), $urandom);
    end
    drain();  // count back at 0, checked by the monitor
endtask

// run length from request count, plus reset
initial begin
    #((resetCycles + (totalReqs + 20) * (numTiles + 2)) * clkPeriod);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
end

initial begin
    void'($urandom(32'h704d_af61));
    for (int c = 0; c < 16; c++)
        for (int w = 0; w < memDepth; w++) model[c][w] = '0;
    arstN          = 1'b0;
    hostReqValid   = 1'b0;
    hostReqOpcode  = OP_RD;
    hostReqAddress = '0;
    hostReqData    = '0;
    repeat (resetCycles) @(negedge QClk);
    arstN = 1'b1;
    resetStateTest();
    targetedWriteTest();
    unclaimedTest();
    broadcastTest();
    burstTest();
    assertErrs = dut0.asrt0.failCount;
    $display("errors: value %0d, latency %0d, missing %0d, assertion %0d",
             valueErrs, latencyErrs, missingErrs, assertErrs);
    if (valueErrs + latencyErrs + missingErrs + assertErrs == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

// File: compile.f
ringPkg.sv
tileMapPkg.sv
ringInjector.sv
ringTile.sv
ringCollector.sv
lotrRing.sv
lotrRing_assertions.sv
lotrRing_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lotrRing_tb -f compile.f -o simv

# keep running past assertion errors so the testbench gives the verdict
./obj_dir/simv +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run.sh: the simulation reported a failure"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: the simulation ended without a verdict"
    exit 1
fi
echo "run.sh: done"
